/* mmu_pkg.sv */
/*
 * shared types for the matrix-multiply unit: operands, accumulators,
 * inter-cell links and controller states
 */

package mmu_pkg;

    //////////////////////////////////////////////////
    // data widths
    //////////////////////////////////////////////////

    localparam int OP_W  = 32;
    localparam int ACC_W = 64;

    // one element of A or B
    typedef logic signed [OP_W-1:0] op_t;

    // running sum per cell, wraps modulo 2^64
    typedef logic signed [ACC_W-1:0] acc_t;

    //////////////////////////////////////////////////
    // mesh link
    //////////////////////////////////////////////////

    // a moves east along a row, b moves south down a column
    typedef struct packed {
        op_t a;
        op_t b;
    } pe_link_t;

    //////////////////////////////////////////////////
    // controller
    //////////////////////////////////////////////////

    // IDLE   waiting for start
    // LOAD   taking DIM beats
    // DRAIN  letting the last beat reach the far corner
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        LOAD  = 2'd1,
        DRAIN = 2'd2,
        DONE  = 2'd3
    } ctrl_state_t;

endpackage

/* mac_pe.sv */
/*
 * single multiply-accumulate cell of the systolic mesh
 */

module mac_pe (
    input  logic               clk,
    input  logic               rst,
    input  logic               clear,
    input  mmu_pkg::pe_link_t  west,
    input  mmu_pkg::pe_link_t  north,
    output mmu_pkg::pe_link_t  east,
    output mmu_pkg::pe_link_t  south,
    output mmu_pkg::acc_t      acc
);

    mmu_pkg::acc_t prod;
    mmu_pkg::acc_t base;

    // both operands sign extended before the multiply
    assign prod = mmu_pkg::acc_t'($signed(west.a)) * mmu_pkg::acc_t'($signed(north.b));

    // clear drops the old sum, a pair arriving in the same cycle still counts
    assign base = clear ? '0 : acc;

    //////////////////////////////////////////////////
    // operand forwarding
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            east  <= '0;
            south <= '0;
        end else begin
            east.a  <= west.a;
            east.b  <= '0;
            south.a <= '0;
            south.b <= north.b;
        end
    end

    //////////////////////////////////////////////////
    // accumulator
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc <= '0;
        end else begin
            acc <= base + prod;
        end
    end

endmodule

/* operand_skew.sv */
/*
 * input skew for the mesh: lane i of A and B delayed by i cycles,
 * zeros injected on cycles without a beat
 */

module operand_skew #(
    parameter int DIM = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               load_en,
    input  mmu_pkg::op_t       a_vec    [DIM],
    input  mmu_pkg::op_t       b_vec    [DIM],
    output mmu_pkg::pe_link_t  west_in  [DIM],
    output mmu_pkg::pe_link_t  north_in [DIM]
);

    // row i of A and column i of B share one lane, same depth
    mmu_pkg::pe_link_t lane_in [DIM];

    for (genvar i = 0; i < DIM; i++) begin : g_lane

        // empty cycles must add nothing downstream
        assign lane_in[i] = load_en ? '{a: a_vec[i], b: b_vec[i]} : '0;

        if (i == 0) begin : g_pass
            // lane 0 goes straight into the corner cell
            assign west_in[i]  = '{a: lane_in[i].a, b: '0};
            assign north_in[i] = '{a: '0, b: lane_in[i].b};
        end else begin : g_delay
            mmu_pkg::pe_link_t stage [i];

            always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                    stage <= '{default: '0};
                end else begin
                    stage[0] <= lane_in[i];
                    for (int k = 1; k < i; k++) begin
                        stage[k] <= stage[k-1];
                    end
                end
            end

            // last stage feeds the edge of the mesh
            assign west_in[i]  = '{a: stage[i-1].a, b: '0};
            assign north_in[i] = '{a: '0, b: stage[i-1].b};
        end

    end

endmodule

/* systolic_array.sv */
/*
 * DIM x DIM mesh of mac_pe cells with east and south operand links
 */

module systolic_array #(
    parameter int DIM = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               clear,
    input  mmu_pkg::pe_link_t  west_in  [DIM],
    input  mmu_pkg::pe_link_t  north_in [DIM],
    output mmu_pkg::acc_t      result   [DIM][DIM]
);

    // registered outputs of every cell
    mmu_pkg::pe_link_t east_q  [DIM][DIM];
    mmu_pkg::pe_link_t south_q [DIM][DIM];

    // what each cell sees on its west and north side
    mmu_pkg::pe_link_t cell_west  [DIM][DIM];
    mmu_pkg::pe_link_t cell_north [DIM][DIM];

    for (genvar i = 0; i < DIM; i++) begin : g_row
        for (genvar j = 0; j < DIM; j++) begin : g_col

            //////////////////////////////////////////////////
            // neighbor wiring
            //////////////////////////////////////////////////

            if (j == 0) begin : g_west_edge
                assign cell_west[i][j] = west_in[i];
            end else begin : g_west_link
                assign cell_west[i][j] = east_q[i][j-1];
            end

            if (i == 0) begin : g_north_edge
                assign cell_north[i][j] = north_in[j];
            end else begin : g_north_link
                assign cell_north[i][j] = south_q[i-1][j];
            end

            //////////////////////////////////////////////////
            // cell
            //////////////////////////////////////////////////

            // last column east and last row south go nowhere
            mac_pe pe_i (
                .clk   (clk),
                .rst   (rst),
                .clear (clear),
                .west  (cell_west[i][j]),
                .north (cell_north[i][j]),
                .east  (east_q[i][j]),
                .south (south_q[i][j]),
                .acc   (result[i][j])
            );

        end
    end

endmodule

/* mmu_ctrl.sv */
/*
 * controller: start handling, beat and drain counting, clear, busy, done
 */

module mmu_ctrl #(
    parameter int DIM = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic in_valid,
    output logic clear,
    output logic load_en,
    output logic busy,
    output logic done
);

    // far corner is 2(DIM-1) edges behind the corner cell
    localparam int DRAIN_CYC = 2 * (DIM - 1);
    localparam int BEAT_W    = $clog2(DIM);
    localparam int DRAIN_W   = $clog2(DRAIN_CYC);

    localparam logic [BEAT_W-1:0]  LAST_BEAT  = BEAT_W'(DIM - 1);
    localparam logic [DRAIN_W-1:0] LAST_DRAIN = DRAIN_W'(DRAIN_CYC - 1);

    mmu_pkg::ctrl_state_t state;
    mmu_pkg::ctrl_state_t state_nxt;

    logic [BEAT_W-1:0]  beat_cnt;
    logic [DRAIN_W-1:0] drain_cnt;

    //////////////////////////////////////////////////
    // outputs decoded from state
    //////////////////////////////////////////////////

    assign load_en = in_valid && (state == mmu_pkg::LOAD);
    assign busy    = (state != mmu_pkg::IDLE);
    assign done    = (state == mmu_pkg::DONE);

    //////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            mmu_pkg::IDLE:  if (start) state_nxt = mmu_pkg::LOAD;
            mmu_pkg::LOAD:  if (load_en && beat_cnt == LAST_BEAT) state_nxt = mmu_pkg::DRAIN;
            mmu_pkg::DRAIN: if (drain_cnt == LAST_DRAIN) state_nxt = mmu_pkg::DONE;
            mmu_pkg::DONE:  state_nxt = mmu_pkg::IDLE;
            default:        state_nxt = mmu_pkg::IDLE;
        endcase
    end

    //////////////////////////////////////////////////
    // state and counters
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= mmu_pkg::IDLE;
            clear     <= 1'b0;
            beat_cnt  <= '0;
            drain_cnt <= '0;
        end else begin
            state <= state_nxt;
            // one pulse right after a start is taken
            clear <= (state == mmu_pkg::IDLE) && start;

            if (state == mmu_pkg::IDLE) begin
                beat_cnt <= '0;
            end else if (load_en) begin
                beat_cnt <= beat_cnt + 1'b1;
            end

            // counts only while draining
            if (state == mmu_pkg::DRAIN) begin
                drain_cnt <= drain_cnt + 1'b1;
            end else begin
                drain_cnt <= '0;
            end
        end
    end

endmodule

/* mmu_top.sv */
/*
 * matrix-multiply unit top: controller, input skew and systolic mesh
 */

module mmu_top #(
    parameter int DIM = 4
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  logic           in_valid,
    input  mmu_pkg::op_t   a_vec  [DIM],
    input  mmu_pkg::op_t   b_vec  [DIM],
    output logic           busy,
    output logic           done,
    output mmu_pkg::acc_t  result [DIM][DIM]
);

    logic clear;
    logic load_en;

    // skewed operands entering the mesh edges
    mmu_pkg::pe_link_t west_in  [DIM];
    mmu_pkg::pe_link_t north_in [DIM];

    mmu_ctrl #(
        .DIM (DIM)
    ) ctrl_i (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .in_valid (in_valid),
        .clear    (clear),
        .load_en  (load_en),
        .busy     (busy),
        .done     (done)
    );

    operand_skew #(
        .DIM (DIM)
    ) skew_i (
        .clk      (clk),
        .rst      (rst),
        .load_en  (load_en),
        .a_vec    (a_vec),
        .b_vec    (b_vec),
        .west_in  (west_in),
        .north_in (north_in)
    );

    systolic_array #(
        .DIM (DIM)
    ) array_i (
        .clk      (clk),
        .rst      (rst),
        .clear    (clear),
        .west_in  (west_in),
        .north_in (north_in),
        .result   (result)
    );

endmodule

/* tb_clock.sv */
/*
 * free-running testbench clock
 */

module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2);
            clk = ~clk;
        end
    end

endmodule

/* mmu_chk.sv */
/*
 * concurrent checks on the controller: done width, clear after start,
 * load_en only in LOAD
 */

module mmu_chk (
    input logic                 clk,
    input logic                 rst,
    input logic                 start,
    input logic                 clear,
    input logic                 load_en,
    input logic                 done,
    input mmu_pkg::ctrl_state_t state
);

    // done never lasts past one cycle
    done_pulse: assert property (@(posedge clk) disable iff (rst) $past(done) |-> !done)
        else $error("done stayed high for more than one cycle");

    // an accepted start is followed by clear
    clear_after_start: assert property (@(posedge clk) disable iff (rst)
        $past(state == mmu_pkg::IDLE && start) |-> clear)
        else $error("clear missing after an accepted start");

    // and clear comes from nowhere else
    clear_only_start: assert property (@(posedge clk) disable iff (rst)
        clear |-> $past(state == mmu_pkg::IDLE && start))
        else $error("clear pulsed without an accepted start");

    load_in_load: assert property (@(posedge clk) disable iff (rst)
        load_en |-> state == mmu_pkg::LOAD)
        else $error("load_en high outside the LOAD state");

endmodule

/* mmu_tb.sv */
/*
 * testbench for the matrix-multiply unit: random and extreme matrices,
 * reference model, compare tasks and watchdog
 */

module mmu_tb;

    localparam int DIM          = 4;
    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 10;
    localparam int DRAIN_EDGES  = 2 * (DIM - 1);
    localparam int MAX_GAP      = 3;
    localparam int HOLD_CYCLES  = 12;
    localparam int N_RUNS       = 10;
    localparam int MARGIN       = 8;
    // start, beats with worst gaps, drain, done cycle and slack
    localparam int RUN_CYCLES   = 2 + DIM * (1 + MAX_GAP) + DRAIN_EDGES + 1 + MARGIN;
    localparam int LIMIT_CYCLES = RESET_CYCLES + N_RUNS * RUN_CYCLES + HOLD_CYCLES;

    localparam mmu_pkg::op_t OP_MAX = 32'sh7fff_ffff;
    localparam mmu_pkg::op_t OP_MIN = 32'sh8000_0000;

    logic clk;
    logic rst;
    logic start;
    logic in_valid;
    logic busy;
    logic done;
    mmu_pkg::op_t  a_vec  [DIM];
    mmu_pkg::op_t  b_vec  [DIM];
    mmu_pkg::acc_t result [DIM][DIM];

    // operands of the current product
    mmu_pkg::op_t  a_m  [DIM][DIM];
    mmu_pkg::op_t  b_m  [DIM][DIM];

    integer seed = 11;

    tb_clock #(
        .PERIOD (PERIOD)
    ) clock_i (
        .clk (clk)
    );

    mmu_top #(
        .DIM (DIM)
    ) mmu_top_i (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .in_valid (in_valid),
        .a_vec    (a_vec),
        .b_vec    (b_vec),
        .busy     (busy),
        .done     (done),
        .result   (result)
    );

    bind mmu_ctrl mmu_chk chk_i (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .clear   (clear),
        .load_en (load_en),
        .done    (done),
        .state   (state)
    );

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////

    task automatic abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_acc(string name, mmu_pkg::acc_t exp, mmu_pkg::acc_t act);
        if (act !== exp) begin
            $display("Fail %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("Fail %s expected %b actual %b", name, exp, act);
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////
    // random values and reference model
    //////////////////////////////////////////////////

    function automatic mmu_pkg::op_t rand_op();
        rand_op = $random(seed);
    endfunction

    function automatic logic rand_bit();
        logic [31:0] r;
        r = $random(seed);
        return r[0];
    endfunction

    function automatic int rand_below(int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    task automatic fill_random();
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                a_m[i][j] = rand_op();
                b_m[i][j] = rand_op();
            end
        end
    endtask

    task automatic fill_const(mmu_pkg::op_t av, mmu_pkg::op_t bv);
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                a_m[i][j] = av;
                b_m[i][j] = bv;
            end
        end
    endtask

    // C[i][j] as a 64-bit wrapped sum of sign-extended products
    function automatic mmu_pkg::acc_t model_elem(int i, int j);
        mmu_pkg::acc_t sum;
        mmu_pkg::acc_t pa;
        mmu_pkg::acc_t pb;
        sum = '0;
        for (int k = 0; k < DIM; k++) begin
            pa = a_m[i][k];
            pb = b_m[k][j];
            sum = sum + pa * pb;
        end
        return sum;
    endfunction

    task automatic check_results(string name);
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                check_acc($sformatf("%s C[%0d][%0d]", name, i, j), model_elem(i, j),
                          result[i][j]);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    // junk on the vectors, the skew must gate it away
    task automatic drive_idle(logic noise);
        in_valid = 1'b0;
        start    = noise ? rand_bit() : 1'b0;
        for (int i = 0; i < DIM; i++) begin
            a_vec[i] = rand_op();
            b_vec[i] = rand_op();
        end
    endtask

    // one full product; noise adds stray start and in_valid strobes
    task automatic run_product(string name, int max_gap, logic noise);
        int gap;
        check_flag($sformatf("%s busy before start", name), 1'b0, busy);
        drive_idle(1'b0);
        start = 1'b1;
        @(negedge clk);
        check_flag($sformatf("%s busy after start", name), 1'b1, busy);
        for (int k = 0; k < DIM; k++) begin
            gap = (max_gap > 0) ? rand_below(max_gap + 1) : 0;
            repeat (gap) begin
                drive_idle(noise);
                @(negedge clk);
                check_flag($sformatf("%s busy in gap", name), 1'b1, busy);
            end
            in_valid = 1'b1;
            start    = noise ? rand_bit() : 1'b0;
            for (int i = 0; i < DIM; i++) begin
                a_vec[i] = a_m[i][k];
                b_vec[i] = b_m[k][i];
            end
            @(negedge clk);
            check_flag($sformatf("%s busy after beat %0d", name, k), 1'b1, busy);
        end
        // done exactly DRAIN_EDGES edges after the last beat
        for (int e = 1; e <= DRAIN_EDGES; e++) begin
            drive_idle(noise);
            if (noise) begin
                in_valid = rand_bit();
            end
            @(negedge clk);
            check_flag($sformatf("%s busy in drain", name), 1'b1, busy);
            check_flag($sformatf("%s done at drain edge %0d", name, e), e == DRAIN_EDGES, done);
        end
        check_results(name);
        // a start during the done cycle is ignored too
        drive_idle(noise);
        @(negedge clk);
        drive_idle(1'b0);
        check_flag($sformatf("%s busy after done", name), 1'b0, busy);
        check_flag($sformatf("%s done after done", name), 1'b0, done);
        check_results($sformatf("%s after done", name));
    endtask

    // idle cycles with in_valid strobes, result must stay put
    task automatic hold_results(string name, int cycles);
        repeat (cycles) begin
            drive_idle(1'b0);
            in_valid = rand_bit();
            @(negedge clk);
            check_flag($sformatf("%s busy", name), 1'b0, busy);
            check_flag($sformatf("%s done", name), 1'b0, done);
            // a_m and b_m still hold the last product's operands
            check_results(name);
        end
        in_valid = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin
        rst      = 1'b1;
        start    = 1'b0;
        in_valid = 1'b0;
        a_vec    = '{default: '0};
        b_vec    = '{default: '0};
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        check_flag("reset done", 1'b0, done);
        check_flag("reset busy", 1'b0, busy);
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                check_acc($sformatf("reset C[%0d][%0d]", i, j), '0, result[i][j]);
            end
        end

        fill_random();
        run_product("back_to_back", 0, 1'b0);

        repeat (3) begin
            fill_random();
            run_product("random_gaps", MAX_GAP, 1'b0);
        end

        // wrap-around of the 64-bit sums
        fill_const(OP_MAX, OP_MAX);
        run_product("all_max", 0, 1'b0);
        fill_const(OP_MIN, OP_MIN);
        run_product("all_min", 0, 1'b0);
        fill_const(OP_MAX, OP_MIN);
        run_product("max_by_min", 0, 1'b0);

        // second run must not see the first run's sums
        fill_random();
        run_product("hold_first", 0, 1'b0);
        hold_results("hold_idle", HOLD_CYCLES);
        fill_random();
        run_product("hold_second", MAX_GAP, 1'b0);

        fill_random();
        run_product("ignored_inputs", MAX_GAP, 1'b1);

        $display("Everything OK");
        $finish;
    end

    // watchdog sized from the worst-case length of all runs
    initial begin
        #(LIMIT_CYCLES * PERIOD);
        $display("timeout: tests still running after %0d clock cycles", LIMIT_CYCLES);
        $display("Something failed");
        $fatal(1);
    end

endmodule

/* mmu.f */
mmu_pkg.sv
mac_pe.sv
operand_skew.sv
systolic_array.sv
mmu_ctrl.sv
mmu_top.sv
tb_clock.sv
mmu_chk.sv
mmu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the matrix-multiply unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module mmu_tb -f mmu.f --Mdir obj_dir -o mmu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/mmu_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Everything OK"; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi
